// File: source/csa_cfg_pkg.sv
package csa_cfg_pkg;

	// field widths of a job and its result.
	localparam int DATA_W = 32;
	localparam int SEED_W = 48;
	localparam int RESULT_W = 64;

	// block number, counted up by the host with each job.
	typedef logic [DATA_W-1:0] block_t;

	// seed as given by the host, zero-extended into the mixing state at load.
	typedef logic [SEED_W-1:0] seed_t;

	// round counts, start is inclusive and end is exclusive.
	typedef logic [DATA_W-1:0] count_t;

	// full mixing state, which is also the result word.
	typedef logic [RESULT_W-1:0] result_t;

endpackage

// File: source/csa_ctl_pkg.sv
package csa_ctl_pkg;

	// number of calculation units behind the dispatcher and collector.
	localparam int UNIT_NUM = 2;

	// mixing round, rotate left then xor then add.
	localparam int MIX_ROT = 7;
	localparam logic [63:0] MIX_CONST = 64'h9e3779b97f4a7c15;

	// calculation unit FSM.
	typedef enum logic [1:0] {
		UNIT_IDLE,
		UNIT_RUN,
		UNIT_DONE
	} unit_state_e;

	// collector FSM.
	typedef enum logic [1:0] {
		COLL_SCAN,
		COLL_READ,
		COLL_EMIT
	} coll_state_e;

endpackage

// File: source/csa_dispatch.sv
`timescale 1ns/1ps

module csa_dispatch (
	input  logic clk,
	input  logic rst_n,

	input  logic job_valid_i,
	input  logic [csa_ctl_pkg::UNIT_NUM-1:0] unit_busy_i,

	output logic [csa_ctl_pkg::UNIT_NUM-1:0] unit_load_o,
	output logic job_full_o
);

	import csa_ctl_pkg::*;

	localparam int IDX_W = $clog2(UNIT_NUM);

	logic [IDX_W-1:0] ptr_q; // unit to try first on the next strobe.
	logic [IDX_W-1:0] other;
	logic [IDX_W-1:0] pick;
	logic pick_ok;
	logic take;

	always_comb begin
		other = ptr_q + 1'b1;
		pick = ptr_q;
		pick_ok = 1'b0;
		if (!unit_busy_i[ptr_q]) begin
			pick = ptr_q;
			pick_ok = 1'b1;
		end else if (!unit_busy_i[other]) begin
			pick = other; // fall back to the second unit.
			pick_ok = 1'b1;
		end
	end

	assign take = job_valid_i & pick_ok; // a strobe while full is dropped.

	always_comb begin
		unit_load_o = '0;
		if (take) begin
			unit_load_o[pick] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end else if (take) begin
			ptr_q <= pick + 1'b1; // step past the unit that was just loaded.
		end
	end

	// the busy levels are registered in the units, so this needs no register.
	assign job_full_o = &unit_busy_i;

endmodule

// File: source/csa_calc_unit.sv
`timescale 1ns/1ps

module csa_calc_unit (
	input  logic clk,
	input  logic rst_n,

	input  logic load_i,
	input  csa_cfg_pkg::block_t block_i,
	input  csa_cfg_pkg::seed_t seed_i,
	input  csa_cfg_pkg::count_t times_i,
	input  csa_cfg_pkg::count_t start_i,

	input  logic ren_i,
	output logic busy_o,
	output logic ready_o,

	output csa_cfg_pkg::block_t block_o,
	output csa_cfg_pkg::seed_t seed_o,
	output csa_cfg_pkg::count_t times_o,
	output csa_cfg_pkg::count_t start_o,
	output csa_cfg_pkg::result_t result_o
);

	import csa_cfg_pkg::*;
	import csa_ctl_pkg::*;

	unit_state_e state_q;

	// job buffer, loaded once and held until the result is read.
	block_t block_q;
	seed_t seed_q;
	count_t times_q;
	count_t start_q;

	count_t idx_q; // round index, runs from start up to times.
	result_t mix_q;
	result_t mix_rot;
	result_t mix_next;

	logic accept;
	logic step;
	logic last;

	assign accept = (state_q == UNIT_IDLE) & load_i;
	assign last = (idx_q >= times_q); // also covers an end count at or below the start.
	assign step = (state_q == UNIT_RUN) & ~last;

	// one reduced mixing round per clock.
	always_comb begin
		mix_rot = (mix_q << MIX_ROT) | (mix_q >> (RESULT_W - MIX_ROT));
		mix_next = (mix_rot ^ {{(RESULT_W - DATA_W){1'b0}}, block_q ^ idx_q}) + MIX_CONST;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= UNIT_IDLE;
		end else begin
			case (state_q)
				UNIT_IDLE: begin
					if (load_i) begin
						state_q <= UNIT_RUN;
					end
				end
				UNIT_RUN: begin
					if (last) begin
						state_q <= UNIT_DONE;
					end
				end
				UNIT_DONE: begin
					if (ren_i) begin
						state_q <= UNIT_IDLE; // the collector has taken the result.
					end
				end
				default: begin
					state_q <= UNIT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			block_q <= block_i;
			seed_q <= seed_i;
			times_q <= times_i;
			start_q <= start_i;
			idx_q <= start_i;
			mix_q <= {{(RESULT_W - SEED_W){1'b0}}, seed_i};
		end else if (step) begin
			idx_q <= idx_q + 1'b1;
			mix_q <= mix_next;
		end
	end

	assign busy_o = (state_q != UNIT_IDLE);
	assign ready_o = (state_q == UNIT_DONE);

	// fields stay put while ready is high, since nothing loads or steps in done.
	assign block_o = block_q;
	assign seed_o = seed_q;
	assign times_o = times_q;
	assign start_o = start_q;
	assign result_o = mix_q;

endmodule

// File: source/csa_collect.sv
`timescale 1ns/1ps

module csa_collect (
	input  logic clk,
	input  logic rst_n,

	input  logic [csa_ctl_pkg::UNIT_NUM-1:0] unit_ready_i,

	input  csa_cfg_pkg::block_t unit0_block_i,
	input  csa_cfg_pkg::seed_t unit0_seed_i,
	input  csa_cfg_pkg::count_t unit0_times_i,
	input  csa_cfg_pkg::count_t unit0_start_i,
	input  csa_cfg_pkg::result_t unit0_result_i,

	input  csa_cfg_pkg::block_t unit1_block_i,
	input  csa_cfg_pkg::seed_t unit1_seed_i,
	input  csa_cfg_pkg::count_t unit1_times_i,
	input  csa_cfg_pkg::count_t unit1_start_i,
	input  csa_cfg_pkg::result_t unit1_result_i,

	output logic [csa_ctl_pkg::UNIT_NUM-1:0] unit_ren_o,

	output csa_cfg_pkg::block_t result_block_o,
	output csa_cfg_pkg::seed_t result_seed_o,
	output csa_cfg_pkg::count_t result_times_o,
	output csa_cfg_pkg::count_t result_start_o,
	output csa_cfg_pkg::result_t result_o,
	output logic result_valid_o,
	output logic seq_error_o
);

	import csa_cfg_pkg::*;
	import csa_ctl_pkg::*;

	localparam int IDX_W = $clog2(UNIT_NUM);

	coll_state_e state_q;
	logic [IDX_W-1:0] scan_q; // unit polled in this cycle.
	logic [IDX_W-1:0] sel_q; // unit being read out.
	block_t last_block_q;

	logic sel_hi;

	assign sel_hi = (sel_q != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= COLL_SCAN;
			scan_q <= '0;
			sel_q <= '0;
			last_block_q <= '0;
			unit_ren_o <= '0;
			result_block_o <= '0;
			result_seed_o <= '0;
			result_times_o <= '0;
			result_start_o <= '0;
			result_o <= '0;
			result_valid_o <= 1'b0;
			seq_error_o <= 1'b0;
		end else begin
			unit_ren_o <= '0;
			result_valid_o <= 1'b0;
			seq_error_o <= 1'b0;
			case (state_q)
				COLL_SCAN: begin
					if (unit_ready_i[scan_q]) begin
						sel_q <= scan_q;
						state_q <= COLL_READ;
					end
					scan_q <= scan_q + 1'b1;
				end
				COLL_READ: begin
					unit_ren_o[sel_q] <= 1'b1; // the unit drops ready at the end of emit.
					state_q <= COLL_EMIT;
				end
				COLL_EMIT: begin
					result_block_o <= sel_hi ? unit1_block_i : unit0_block_i;
					result_seed_o <= sel_hi ? unit1_seed_i : unit0_seed_i;
					result_times_o <= sel_hi ? unit1_times_i : unit0_times_i;
					result_start_o <= sel_hi ? unit1_start_i : unit0_start_i;
					result_o <= sel_hi ? unit1_result_i : unit0_result_i;
					result_valid_o <= 1'b1;
					seq_error_o <= (sel_hi ? unit1_block_i : unit0_block_i) != last_block_q + 1'b1;
					last_block_q <= sel_hi ? unit1_block_i : unit0_block_i;
					state_q <= COLL_SCAN;
				end
				default: begin
					state_q <= COLL_SCAN;
				end
			endcase
		end
	end

endmodule

// File: source/csa_search_top.sv
`timescale 1ns/1ps

module csa_search_top (
	input  logic clk,
	input  logic rst_n,

	input  logic job_valid_i,
	input  csa_cfg_pkg::block_t block_i,
	input  csa_cfg_pkg::seed_t seed_i,
	input  csa_cfg_pkg::count_t times_i,
	input  csa_cfg_pkg::count_t times_start_i,
	output logic job_full_o,

	output csa_cfg_pkg::block_t result_block_o,
	output csa_cfg_pkg::seed_t result_seed_o,
	output csa_cfg_pkg::count_t result_times_o,
	output csa_cfg_pkg::count_t result_start_o,
	output csa_cfg_pkg::result_t result_o,
	output logic result_valid_o,
	output logic seq_error_o
);

	import csa_cfg_pkg::*;
	import csa_ctl_pkg::*;

	logic [UNIT_NUM-1:0] unit_busy;
	logic [UNIT_NUM-1:0] unit_load;
	logic [UNIT_NUM-1:0] unit_ready;
	logic [UNIT_NUM-1:0] unit_ren;

	block_t u0_block, u1_block;
	seed_t u0_seed, u1_seed;
	count_t u0_times, u1_times;
	count_t u0_start, u1_start;
	result_t u0_result, u1_result;

	csa_dispatch u_dispatch (
		.clk(clk), .rst_n(rst_n), .job_valid_i(job_valid_i),
		.unit_busy_i(unit_busy), .unit_load_o(unit_load), .job_full_o(job_full_o)
	);

	// both units see the same job fields, only the load pulse differs.
	csa_calc_unit u_unit0 (
		.clk(clk), .rst_n(rst_n), .load_i(unit_load[0]),
		.block_i(block_i), .seed_i(seed_i), .times_i(times_i), .start_i(times_start_i),
		.ren_i(unit_ren[0]), .busy_o(unit_busy[0]), .ready_o(unit_ready[0]),
		.block_o(u0_block), .seed_o(u0_seed), .times_o(u0_times), .start_o(u0_start),
		.result_o(u0_result)
	);

	csa_calc_unit u_unit1 (
		.clk(clk), .rst_n(rst_n), .load_i(unit_load[1]),
		.block_i(block_i), .seed_i(seed_i), .times_i(times_i), .start_i(times_start_i),
		.ren_i(unit_ren[1]), .busy_o(unit_busy[1]), .ready_o(unit_ready[1]),
		.block_o(u1_block), .seed_o(u1_seed), .times_o(u1_times), .start_o(u1_start),
		.result_o(u1_result)
	);

	csa_collect u_collect (
		.clk(clk), .rst_n(rst_n), .unit_ready_i(unit_ready),
		.unit0_block_i(u0_block), .unit0_seed_i(u0_seed), .unit0_times_i(u0_times),
		.unit0_start_i(u0_start), .unit0_result_i(u0_result),
		.unit1_block_i(u1_block), .unit1_seed_i(u1_seed), .unit1_times_i(u1_times),
		.unit1_start_i(u1_start), .unit1_result_i(u1_result),
		.unit_ren_o(unit_ren),
		.result_block_o(result_block_o), .result_seed_o(result_seed_o),
		.result_times_o(result_times_o), .result_start_o(result_start_o),
		.result_o(result_o), .result_valid_o(result_valid_o), .seq_error_o(seq_error_o)
	);

endmodule

// File: bench/csa_search_tb.sv
`timescale 1ns/1ps

module csa_search_tb;

	localparam int JOB_NUM = 14;
	localparam int TEST_NUM = 6;
	localparam logic [63:0] MIX_K = 64'h9e3779b97f4a7c15;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic job_valid_i = 1'b0;
	logic [31:0] block_i = '0;
	logic [47:0] seed_i = '0;
	logic [31:0] times_i = '0;
	logic [31:0] times_start_i = '0;
	logic job_full_o;
	logic [31:0] result_block_o;
	logic [47:0] result_seed_o;
	logic [31:0] result_times_o;
	logic [31:0] result_start_o;
	logic [63:0] result_o;
	logic result_valid_o;
	logic seq_error_o;

	// job table, one row per strobe.
	int test_tab [JOB_NUM];
	logic [31:0] blk_tab [JOB_NUM];
	logic [47:0] seed_tab [JOB_NUM];
	logic [31:0] start_tab [JOB_NUM];
	logic [31:0] times_tab [JOB_NUM];
	int wait_tab [JOB_NUM]; // idle cycles before the strobe.
	logic [1:0] seq_tab [JOB_NUM]; // 2 means the flag follows the arrival order.
	logic got_tab [JOB_NUM];

	integer seed_var = 32'h841a;
	int job_cnt = 0;
	int cycle_limit = 0;
	int err_count = 0;
	int test_err = 0;
	int fail_tests = 0;
	logic saw_full = 1'b0;
	logic [31:0] last_blk = '0;

	csa_search_top u_csa_search_top (
		.clk(clk), .rst_n(rst_n), .job_valid_i(job_valid_i),
		.block_i(block_i), .seed_i(seed_i), .times_i(times_i), .times_start_i(times_start_i),
		.job_full_o(job_full_o),
		.result_block_o(result_block_o), .result_seed_o(result_seed_o),
		.result_times_o(result_times_o), .result_start_o(result_start_o),
		.result_o(result_o), .result_valid_o(result_valid_o), .seq_error_o(seq_error_o)
	);

	initial begin
		forever begin
			#4 clk = ~clk;
		end
	end

	function automatic logic [63:0] mix_ref(input logic [31:0] blk, input logic [47:0] seed,
			input logic [31:0] start, input logic [31:0] times);
		logic [63:0] st;
		logic [31:0] r;
		st = {16'h0, seed};
		for (r = start; r < times; r++) begin
			st = {st[56:0], st[63:57]};
			st[31:0] = st[31:0] ^ blk ^ r;
			st = st + MIX_K;
		end
		return st;
	endfunction

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic add_job(input int t, input logic [31:0] blk, input logic [31:0] start,
			input logic [31:0] times, input int wait_cyc, input logic [1:0] seq);
		logic [63:0] rnd64;
		rnd64 = {$random(seed_var), $random(seed_var)};
		test_tab[job_cnt] = t;
		blk_tab[job_cnt] = blk;
		seed_tab[job_cnt] = rnd64[47:0];
		start_tab[job_cnt] = start;
		times_tab[job_cnt] = times;
		wait_tab[job_cnt] = wait_cyc;
		seq_tab[job_cnt] = seq;
		got_tab[job_cnt] = 1'b0;
		cycle_limit += (times > start) ? int'(times - start) + 20 : 20;
		job_cnt++;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		logic [31:0] start;
		logic [31:0] rounds;
		add_job(2, 32'd1, 32'd0, 32'd10, 2, 2'd0);
		add_job(3, 32'd2, 32'd17, 32'd17, 2, 2'd0);
		add_job(4, 32'd3, 32'd4, 32'd16, 2, 2'd0);
		add_job(4, 32'd4, 32'd4, 32'd16, 0, 2'd0); // strobed on the very next edge.
		add_job(5, 32'd5, 32'd0, 32'd40, 2, 2'd1);
		add_job(5, 32'd6, 32'd8, 32'd10, 1, 2'd1);
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed_var);
			start = rnd % 32'd100;
			rnd = $random(seed_var);
			rounds = rnd % 32'd31;
			rnd = $random(seed_var);
			add_job(6, 32'(7 + i), start, start + rounds, 1 + int'(rnd % 32'd3), 2'd2);
		end
		cycle_limit += 100;
	endtask

	task automatic send_job(input int i);
		if (wait_tab[i] > 0) begin
			@(posedge clk);
			job_valid_i <= 1'b0;
			repeat (wait_tab[i] - 1) @(posedge clk);
		end
		@(negedge clk);
		while (job_full_o) @(negedge clk);
		@(posedge clk);
		job_valid_i <= 1'b1;
		block_i <= blk_tab[i];
		seed_i <= seed_tab[i];
		times_i <= times_tab[i];
		times_start_i <= start_tab[i];
	endtask

	task automatic report_test(input int t);
		if (err_count == test_err) begin
			$display("test %0d ok", t);
		end else begin
			$display("test %0d FAIL with %0d errors", t, err_count - test_err);
			fail_tests++;
		end
		test_err = err_count;
		saw_full = 1'b0;
	endtask

	task automatic finish_group(input int t);
		int pending;
		@(posedge clk);
		job_valid_i <= 1'b0;
		pending = 1;
		while (pending > 0) begin
			@(negedge clk);
			pending = 0;
			for (int k = 0; k < job_cnt; k++) begin
				if (test_tab[k] == t && !got_tab[k]) begin
					pending++;
				end
			end
		end
		if (t == 4 && !saw_full) begin
			$display("job_full_o never went high while both jobs of test 4 ran");
			err_count++;
		end
		report_test(t);
	endtask

	initial begin
		int cur;
		build_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (12) begin
			@(negedge clk);
			check_val(64'({result_valid_o, seq_error_o, job_full_o}), 64'h0, "flags after reset");
			check_val(result_o, 64'h0, "result after reset");
			check_val(64'(result_seed_o) | 64'(result_block_o | result_times_o | result_start_o),
				64'h0, "echoed fields after reset");
		end
		report_test(1);
		cur = test_tab[0];
		for (int i = 0; i < job_cnt; i++) begin
			if (test_tab[i] != cur) begin
				finish_group(cur);
				cur = test_tab[i];
			end
			send_job(i);
		end
		finish_group(cur);
		$display("done, %0d tests run, %0d failing, %0d errors", TEST_NUM, fail_tests, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// results are matched to the table by block number, in whatever order they arrive.
	initial begin
		int hit;
		logic exp_seq;
		forever begin
			@(negedge clk);
			if (job_full_o) begin
				saw_full = 1'b1;
			end
			if (seq_error_o && !result_valid_o) begin
				$display("seq_error_o went high without a result at %0t ns", $time);
				err_count++;
			end
			if (result_valid_o) begin
				hit = -1;
				for (int k = 0; k < job_cnt; k++) begin
					if (hit < 0 && !got_tab[k] && blk_tab[k] == result_block_o) begin
						hit = k;
					end
				end
				if (hit < 0) begin
					$display("a result came back for block %0d, which was never sent", result_block_o);
					err_count++;
				end else begin
					got_tab[hit] = 1'b1;
					check_val(64'(result_seed_o), 64'(seed_tab[hit]), "seed echo");
					check_val(64'(result_times_o), 64'(times_tab[hit]), "end count echo");
					check_val(64'(result_start_o), 64'(start_tab[hit]), "start count echo");
					check_val(result_o, mix_ref(blk_tab[hit], seed_tab[hit], start_tab[hit],
						times_tab[hit]), "mixing result");
					if (times_tab[hit] <= start_tab[hit]) begin
						check_val(result_o, {16'h0, seed_tab[hit]}, "result of a job with no rounds");
					end
					exp_seq = (seq_tab[hit] == 2'd2) ? (result_block_o != last_blk + 32'd1) :
						seq_tab[hit][0];
					check_val(64'(seq_error_o), 64'(exp_seq), "seq_error_o");
					last_blk = result_block_o;
				end
			end
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("results did not arrive within %0d cycles, so the run was stopped", cycle_limit);
		$display("tests failed");
		$finish;
	end

endmodule

// File: compile.f
source/csa_cfg_pkg.sv
source/csa_ctl_pkg.sv
source/csa_dispatch.sv
source/csa_calc_unit.sv
source/csa_collect.sv
source/csa_search_top.sv
bench/csa_search_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the fail message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module csa_search_tb \
	-f compile.f -o csa_search_sim > build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }
./obj_dir/csa_search_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && echo "FAIL" && exit 1 || echo "PASS"
